//--- hdl/icache_config.svh
// Instruction cache geometry and widths
// AXI4 read master constants for the line refill

`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// Fetch side
`define ICACHE_ADDR_W       32
`define ICACHE_DATA_W       128    // One fetch word per line
`define ICACHE_ID_W         8

// Cache organisation
`define ICACHE_NUM_WAYS     2
`define ICACHE_WAY_W        1      // log2 of the way count
`define ICACHE_NUM_SETS     16
`define ICACHE_OFFSET_W     4      // Byte offset inside a line
`define ICACHE_INDEX_W      4
`define ICACHE_TAG_W        (`ICACHE_ADDR_W - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)

// AXI4 read master
`define ICACHE_AXI_DATA_W   64
`define ICACHE_AXI_ID_W     4
`define ICACHE_AXI_ID       (`ICACHE_AXI_ID_W'(1))
`define ICACHE_BURST_BEATS  2      // Beats per line refill

`endif

//--- hdl/icache_pkg.sv
// Bundled types of the instruction cache
// Fetch request/response, AXI AR and R payloads, lookup result, FSM states

`include "icache_config.svh"

package icache_pkg;

   // -------------------------------------------------------------------------
   // Fetch port
   // -------------------------------------------------------------------------
   typedef struct packed {
      logic [`ICACHE_ADDR_W-1:0] addr;
      logic [`ICACHE_ID_W-1:0]   id;
   } fetch_req_t;

   typedef struct packed {
      logic [`ICACHE_DATA_W-1:0] data;
      logic [`ICACHE_ID_W-1:0]   id;    // Echo of the request ID
   } fetch_rsp_t;

   // -------------------------------------------------------------------------
   // AXI4 read channels
   // -------------------------------------------------------------------------
   typedef struct packed {
      logic [`ICACHE_AXI_ID_W-1:0] id;
      logic [`ICACHE_ADDR_W-1:0]   addr;
      logic [7:0]                  len;    // Beats minus one
      logic [2:0]                  size;   // log2 of bytes per beat
      logic [1:0]                  burst;  // 2'b01 is INCR
   } ar_req_t;

   typedef struct packed {
      logic [`ICACHE_AXI_ID_W-1:0]   id;
      logic [`ICACHE_AXI_DATA_W-1:0] data;
      logic [1:0]                    resp;
      logic                          last;
   } r_beat_t;

   // Tag array answer, valid one cycle after the lookup strobe
   typedef struct packed {
      logic                     hit;
      logic [`ICACHE_WAY_W-1:0] hit_way;
      logic [`ICACHE_WAY_W-1:0] victim_way;
   } tag_lookup_t;

   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      REFILL,
      RESPOND,
      FLUSH
   } icache_state_e;

endpackage

//--- hdl/icache_tag_array.sv
// Tag storage with per-way valid bits
// Registered-index hit compare and round-robin victim pointer per set

`timescale 1ns/1ps
`include "icache_config.svh"

module icache_tag_array
(
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         lookup_i,
   input  logic [`ICACHE_INDEX_W-1:0]   index_i,
   input  logic [`ICACHE_TAG_W-1:0]     tag_i,      // Compare tag, also the write tag
   input  logic                         write_i,
   input  logic [`ICACHE_WAY_W-1:0]     way_i,
   input  logic                         flush_i,
   output icache_pkg::tag_lookup_t      result_o
);

   logic [`ICACHE_TAG_W-1:0]                           tag_mem [`ICACHE_NUM_WAYS][`ICACHE_NUM_SETS];
   logic [`ICACHE_NUM_WAYS-1:0][`ICACHE_NUM_SETS-1:0]  valid_q;
   logic [`ICACHE_NUM_SETS-1:0][`ICACHE_WAY_W-1:0]     victim_q;
   logic [`ICACHE_INDEX_W-1:0]                         index_q;
   logic [`ICACHE_NUM_WAYS-1:0]                        way_hit;

   always_ff @(posedge clk)
   begin
      if (write_i)
         tag_mem[way_i][index_i] <= tag_i;
   end

   // Valid bits, victim pointers and the looked-up index
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         valid_q  <= '0;
         victim_q <= '0;
         index_q  <= '0;
      end
      else
      begin
         if (lookup_i)
            index_q <= index_i;
         if (flush_i)
            valid_q <= '0;                  // Whole cache in one cycle
         else if (write_i)
         begin
            valid_q[way_i][index_i] <= 1'b1;
            victim_q[index_i]       <= victim_q[index_i] + 1'b1;
         end
      end
   end

   for (genvar w = 0; w < `ICACHE_NUM_WAYS; w++)
   begin : g_way_cmp
      assign way_hit[w] = valid_q[w][index_q] && (tag_mem[w][index_q] == tag_i);
   end

   always_comb
   begin
      result_o.hit        = 1'b0;
      result_o.hit_way    = '0;
      result_o.victim_way = victim_q[index_q];
      for (int w = 0; w < `ICACHE_NUM_WAYS; w++)
      begin
         if (way_hit[w])
         begin
            result_o.hit     = 1'b1;
            result_o.hit_way = `ICACHE_WAY_W'(w);
         end
      end
   end

endmodule

//--- hdl/icache_data_array.sv
// Line storage, one array per way
// Both ways read together, then selected by the hit way

`timescale 1ns/1ps
`include "icache_config.svh"

module icache_data_array
(
   input  logic                         clk,
   input  logic                         lookup_i,
   input  logic [`ICACHE_INDEX_W-1:0]   index_i,
   input  logic [`ICACHE_WAY_W-1:0]     hit_way_i,
   input  logic                         write_i,
   input  logic [`ICACHE_WAY_W-1:0]     way_i,
   input  logic [`ICACHE_DATA_W-1:0]    wdata_i,
   output logic [`ICACHE_DATA_W-1:0]    rdata_o
);

   logic [`ICACHE_NUM_WAYS-1:0][`ICACHE_DATA_W-1:0] rd_q;   // Read register per way

   for (genvar w = 0; w < `ICACHE_NUM_WAYS; w++)
   begin : g_way
      logic [`ICACHE_DATA_W-1:0] line_mem [`ICACHE_NUM_SETS];

      always_ff @(posedge clk)
      begin
         if (write_i && (way_i == `ICACHE_WAY_W'(w)))
            line_mem[index_i] <= wdata_i;
         if (lookup_i)
            rd_q[w] <= line_mem[index_i];
      end
   end

   // Way mux
   assign rdata_o = rd_q[hit_way_i];

endmodule

//--- hdl/icache_refill.sv
// AXI4 read refill of one line
// AR issue, then two R beats combined into a full line

`timescale 1ns/1ps
`include "icache_config.svh"

module icache_refill
(
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         start_i,
   input  logic [`ICACHE_ADDR_W-1:0]    addr_i,      // Line aligned
   // AR channel
   output logic                         ar_valid_o,
   output icache_pkg::ar_req_t          ar_o,
   input  logic                         ar_ready_i,
   // R channel
   input  logic                         r_valid_i,
   input  icache_pkg::r_beat_t          r_i,
   output logic                         r_ready_o,
   // Assembled line
   output logic                         done_o,
   output logic [`ICACHE_DATA_W-1:0]    line_o
);

   logic [`ICACHE_ADDR_W-1:0]                              addr_q;
   logic [`ICACHE_BURST_BEATS-1:0][`ICACHE_AXI_DATA_W-1:0] beat_q;
   logic                                                   beat_idx_q;   // Toggles per beat
   logic                                                   r_fire;

   assign r_fire = r_valid_i && r_ready_o;

   // AR fields stay constant apart from the address
   assign ar_o.id    = `ICACHE_AXI_ID;
   assign ar_o.addr  = addr_q;
   assign ar_o.len   = 8'(`ICACHE_BURST_BEATS - 1);
   assign ar_o.size  = 3'($clog2(`ICACHE_AXI_DATA_W / 8));
   assign ar_o.burst = 2'b01;                     // INCR

   // First beat is the low half of the line
   assign line_o = beat_q;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         ar_valid_o <= 1'b0;
         r_ready_o  <= 1'b0;
         done_o     <= 1'b0;
         beat_idx_q <= 1'b0;
      end
      else
      begin
         done_o <= r_fire && r_i.last;
         if (start_i)
            ar_valid_o <= 1'b1;
         else if (ar_valid_o && ar_ready_i)
         begin
            ar_valid_o <= 1'b0;
            r_ready_o  <= 1'b1;                   // Accept beats once AR is taken
         end
         if (r_fire)
         begin
            beat_idx_q <= ~beat_idx_q;
            if (r_i.last)
            begin
               r_ready_o  <= 1'b0;
               beat_idx_q <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (start_i)
         addr_q <= addr_i;
      if (r_fire)
         beat_q[beat_idx_q] <= r_i.data;
   end

endmodule

//--- hdl/icache_ctrl.sv
// Cache control FSM
// Fetch handshake, hit/miss decision, refill sequencing and whole-cache flush

`timescale 1ns/1ps
`include "icache_config.svh"

module icache_ctrl
(
   input  logic                          clk,
   input  logic                          rst_n,
   // Fetch port
   input  logic                          fetch_req_i,
   input  icache_pkg::fetch_req_t        fetch_i,
   output logic                          fetch_grant_o,
   output logic                          fetch_valid_o,
   output icache_pkg::fetch_rsp_t        fetch_rsp_o,
   // Flush control
   input  logic                          ctrl_flush_req_i,
   output logic                          ctrl_flush_ack_o,
   // Tag array
   output logic                          lookup_o,
   output logic [`ICACHE_INDEX_W-1:0]    index_o,
   input  icache_pkg::tag_lookup_t       lookup_i,
   output logic                          tag_write_o,
   output logic [`ICACHE_WAY_W-1:0]      tag_way_o,
   output logic [`ICACHE_TAG_W-1:0]      tag_o,
   output logic                          flush_o,
   // Data array
   input  logic [`ICACHE_DATA_W-1:0]     rd_line_i,
   output logic                          fill_write_o,
   output logic [`ICACHE_DATA_W-1:0]     fill_line_o,
   // Refill unit
   output logic                          refill_start_o,
   output logic [`ICACHE_ADDR_W-1:0]     refill_addr_o,
   input  logic                          refill_done_i,
   input  logic [`ICACHE_DATA_W-1:0]     refill_line_i
);
   import icache_pkg::*;

   icache_state_e               state_q;
   icache_state_e               state_d;
   fetch_req_t                  req_q;      // Request in flight
   logic [`ICACHE_DATA_W-1:0]   line_q;     // Response line
   logic [`ICACHE_WAY_W-1:0]    victim_q;
   logic                        accept;
   logic                        fill;

   // Only one request in flight, flush wins over a new fetch
   assign fetch_grant_o = (state_q == IDLE) && !ctrl_flush_req_i;
   assign accept        = fetch_req_i && fetch_grant_o;

   // Lookup index comes straight from the port, later from the saved request
   assign lookup_o = accept;
   assign index_o  = (state_q == IDLE) ? fetch_i.addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W]
                                       : req_q.addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
   assign tag_o    = req_q.addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];

   // Miss handling
   assign refill_start_o = (state_q == LOOKUP) && !lookup_i.hit;
   assign refill_addr_o  = {req_q.addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W],
                            {`ICACHE_OFFSET_W{1'b0}}};

   // Refilled line goes to the victim way and to the requester together
   assign fill         = (state_q == REFILL) && refill_done_i;
   assign tag_write_o  = fill;
   assign tag_way_o    = victim_q;
   assign fill_write_o = fill;
   assign fill_line_o  = refill_line_i;

   assign flush_o          = (state_q == FLUSH);
   assign ctrl_flush_ack_o = (state_q == FLUSH);   // Single cycle ack

   assign fetch_valid_o    = (state_q == RESPOND);
   assign fetch_rsp_o.data = line_q;
   assign fetch_rsp_o.id   = req_q.id;

   // --------------------------------------------------------------------------
   // State machine
   // --------------------------------------------------------------------------
   always_comb
   begin
      state_d = state_q;
      case (state_q)
         IDLE:
         begin
            if (ctrl_flush_req_i)
               state_d = FLUSH;
            else if (accept)
               state_d = LOOKUP;
         end
         LOOKUP:  state_d = lookup_i.hit ? RESPOND : REFILL;
         REFILL:
         begin
            if (refill_done_i)
               state_d = RESPOND;
         end
         RESPOND: state_d = IDLE;
         FLUSH:   state_d = IDLE;
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         state_q <= IDLE;
      else
         state_q <= state_d;
   end

   // Request, victim and response line
   always_ff @(posedge clk)
   begin
      if (accept)
         req_q <= fetch_i;
      if (state_q == LOOKUP)
      begin
         line_q   <= rd_line_i;              // Hit data, overwritten on a refill
         victim_q <= lookup_i.victim_way;
      end
      if (fill)
         line_q <= refill_line_i;
   end

endmodule

//--- hdl/shared_icache.sv
// Shared instruction cache, two-way set associative
// Controller, tag array, data array and AXI refill unit

`timescale 1ns/1ps
`include "icache_config.svh"

module shared_icache
(
   input  logic                    clk,
   input  logic                    rst_n,
   // Fetch port
   input  logic                    fetch_req_i,
   input  icache_pkg::fetch_req_t  fetch_i,
   output logic                    fetch_grant_o,
   output logic                    fetch_valid_o,
   output icache_pkg::fetch_rsp_t  fetch_rsp_o,
   // AXI4 read master
   output logic                    ar_valid_o,
   output icache_pkg::ar_req_t     ar_o,
   input  logic                    ar_ready_i,
   input  logic                    r_valid_i,
   input  icache_pkg::r_beat_t     r_i,
   output logic                    r_ready_o,
   // Flush control
   input  logic                    ctrl_flush_req_i,
   output logic                    ctrl_flush_ack_o
);
   import icache_pkg::*;

   logic                         lookup;
   logic [`ICACHE_INDEX_W-1:0]   index;
   tag_lookup_t                  tag_result;
   logic                         tag_write;
   logic [`ICACHE_WAY_W-1:0]     tag_way;     // Victim way, shared by tag and data write
   logic [`ICACHE_TAG_W-1:0]     tag;
   logic                         flush;
   logic [`ICACHE_DATA_W-1:0]    rd_line;
   logic                         fill_write;
   logic [`ICACHE_DATA_W-1:0]    fill_line;
   logic                         refill_start;
   logic [`ICACHE_ADDR_W-1:0]    refill_addr;
   logic                         refill_done;
   logic [`ICACHE_DATA_W-1:0]    refill_line;

   icache_ctrl u_ctrl
   (
      .clk              ( clk              ),
      .rst_n            ( rst_n            ),
      .fetch_req_i      ( fetch_req_i      ),
      .fetch_i          ( fetch_i          ),
      .fetch_grant_o    ( fetch_grant_o    ),
      .fetch_valid_o    ( fetch_valid_o    ),
      .fetch_rsp_o      ( fetch_rsp_o      ),
      .ctrl_flush_req_i ( ctrl_flush_req_i ),
      .ctrl_flush_ack_o ( ctrl_flush_ack_o ),
      .lookup_o         ( lookup           ),
      .index_o          ( index            ),
      .lookup_i         ( tag_result       ),
      .tag_write_o      ( tag_write        ),
      .tag_way_o        ( tag_way          ),
      .tag_o            ( tag              ),
      .flush_o          ( flush            ),
      .rd_line_i        ( rd_line          ),
      .fill_write_o     ( fill_write       ),
      .fill_line_o      ( fill_line        ),
      .refill_start_o   ( refill_start     ),
      .refill_addr_o    ( refill_addr      ),
      .refill_done_i    ( refill_done      ),
      .refill_line_i    ( refill_line      )
   );

   icache_tag_array u_tag_array
   (
      .clk      ( clk        ),
      .rst_n    ( rst_n      ),
      .lookup_i ( lookup     ),
      .index_i  ( index      ),
      .tag_i    ( tag        ),
      .write_i  ( tag_write  ),
      .way_i    ( tag_way    ),
      .flush_i  ( flush      ),
      .result_o ( tag_result )
   );

   icache_data_array u_data_array
   (
      .clk       ( clk                ),
      .lookup_i  ( lookup             ),
      .index_i   ( index              ),
      .hit_way_i ( tag_result.hit_way ),
      .write_i   ( fill_write         ),
      .way_i     ( tag_way            ),
      .wdata_i   ( fill_line          ),
      .rdata_o   ( rd_line            )
   );

   icache_refill u_refill
   (
      .clk        ( clk          ),
      .rst_n      ( rst_n        ),
      .start_i    ( refill_start ),
      .addr_i     ( refill_addr  ),
      .ar_valid_o ( ar_valid_o   ),
      .ar_o       ( ar_o         ),
      .ar_ready_i ( ar_ready_i   ),
      .r_valid_i  ( r_valid_i    ),
      .r_i        ( r_i          ),
      .r_ready_o  ( r_ready_o    ),
      .done_o     ( refill_done  ),
      .line_o     ( refill_line  )
   );

endmodule

//--- dv/tb_shared_icache.sv
// Testbench of the shared instruction cache
// AXI read memory model, hit/miss model, reference line function, checks and watchdog

`timescale 1ns/1ps
`include "icache_config.svh"

module tb_shared_icache;
   import icache_pkg::*;

   localparam int RSP_W      = `ICACHE_DATA_W + `ICACHE_ID_W;
   localparam int CLK_PERIOD = 4;
   localparam int SEED       = 18;
   localparam int NUM_REQS   = 212;                  // All fetches of all tests
   localparam int WORST_CYC  = 32;                   // Grant, AR stall, beat gaps, respond
   localparam int TIMEOUT_NS = (NUM_REQS * WORST_CYC + 100) * CLK_PERIOD;

   logic             clk;
   logic             rst_n;
   logic             fetch_req_i;
   fetch_req_t       fetch_i;
   logic             fetch_grant_o;
   logic             fetch_valid_o;
   fetch_rsp_t       fetch_rsp_o;
   logic             ar_valid_o;
   ar_req_t          ar_o;
   logic             ar_ready_i;
   logic             r_valid_i;
   r_beat_t          r_i;
   logic             r_ready_o;
   logic             ctrl_flush_req_i;
   logic             ctrl_flush_ack_o;

   logic [31:0]      stim_rng;
   logic [31:0]      mem_rng;
   logic             delays;                         // Random AR/R stalls on
   logic [31:0]      cur_line;                       // Line address of the request in flight
   int               ar_count;
   int               miss_count;
   logic [RSP_W-1:0] exp_q[$];

   // Hit/miss model
   logic             model_valid [`ICACHE_NUM_WAYS][`ICACHE_NUM_SETS];
   logic [23:0]      model_tag [`ICACHE_NUM_WAYS][`ICACHE_NUM_SETS];
   logic             model_victim [`ICACHE_NUM_SETS];

   shared_icache uut
   (
      .clk              ( clk              ),
      .rst_n            ( rst_n            ),
      .fetch_req_i      ( fetch_req_i      ),
      .fetch_i          ( fetch_i          ),
      .fetch_grant_o    ( fetch_grant_o    ),
      .fetch_valid_o    ( fetch_valid_o    ),
      .fetch_rsp_o      ( fetch_rsp_o      ),
      .ar_valid_o       ( ar_valid_o       ),
      .ar_o             ( ar_o             ),
      .ar_ready_i       ( ar_ready_i       ),
      .r_valid_i        ( r_valid_i        ),
      .r_i              ( r_i              ),
      .r_ready_o        ( r_ready_o        ),
      .ctrl_flush_req_i ( ctrl_flush_req_i ),
      .ctrl_flush_ack_o ( ctrl_flush_ack_o )
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // -------------------------------------------------------------------------
   // Reference functions
   // -------------------------------------------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Memory content, every address bit shows up in the word
   function automatic logic [63:0] mem_word(input logic [31:0] addr);
      return {addr ^ 32'hc3a5_0f1e, (addr * 32'h9e37_79b1) ^ 32'h0123_4567};
   endfunction

   function automatic logic [127:0] ref_line(input logic [31:0] addr);
      logic [31:0] base;
      base = {addr[31:4], 4'h0};
      return {mem_word(base + 32'd8), mem_word(base)};   // Low beat first
   endfunction

   // Predicts hit or miss, and on a miss fills the victim way
   function automatic logic model_access(input logic [31:0] addr);
      logic [3:0]  set;
      logic [23:0] tag;
      logic        hit;
      int          way;
      set = addr[7:4];
      tag = addr[31:8];
      hit = 1'b0;
      for (int w = 0; w < `ICACHE_NUM_WAYS; w++)
         if (model_valid[w][set] && model_tag[w][set] == tag)
            hit = 1'b1;
      if (!hit)
      begin
         way                   = model_victim[set];
         model_valid[way][set] = 1'b1;
         model_tag[way][set]   = tag;
         model_victim[set]     = !model_victim[set];
         miss_count++;
      end
      return hit;
   endfunction

   // -------------------------------------------------------------------------
   // Failure reporting
   // -------------------------------------------------------------------------
   task automatic report_fail(input string reason);
      $display("%s", reason);
      $display("Finished with errors");
      $fatal(1, "stopped at the first failure");
   endtask

   task automatic check(input string name, input logic [RSP_W-1:0] got,
                        input logic [RSP_W-1:0] exp);
      if (got !== exp)
         report_fail($sformatf("ERR %0t %s got %0h expected %0h", $time, name, got, exp));
   endtask

   // -------------------------------------------------------------------------
   // Stimulus tasks
   // -------------------------------------------------------------------------
   task automatic fetch(input logic [31:0] addr, input logic [7:0] id, output logic hit_o);
      int   ar_before;
      int   cycles;
      logic exp_hit;
      exp_hit   = model_access(addr);
      ar_before = ar_count;
      @(posedge clk);
      #1;
      cur_line = {addr[31:4], 4'h0};
      exp_q.push_back({ref_line(addr), id});
      fetch_req_i  = 1'b1;
      fetch_i.addr = addr;
      fetch_i.id   = id;
      @(negedge clk);
      while (!fetch_grant_o)
         @(negedge clk);
      @(posedge clk);                                // Accepting edge
      #1;
      fetch_req_i = 1'b0;
      cycles      = 0;
      do
      begin
         @(negedge clk);
         cycles++;
      end while (!fetch_valid_o);
      if (exp_hit)
         check("hit latency", cycles, 2);
      @(negedge clk);
      check("fetch_valid_o pulse", fetch_valid_o, 0);
      check("AR count per fetch", ar_count - ar_before, exp_hit ? 0 : 1);
      hit_o = (ar_count == ar_before);               // The DUT hit when no AR went out
   endtask

   task automatic flush_cache();
      int cycles;
      @(posedge clk);
      #1;
      ctrl_flush_req_i = 1'b1;
      @(negedge clk);
      check("fetch_grant_o during flush", fetch_grant_o, 0);
      @(posedge clk);                                // Request seen in IDLE
      cycles = 0;
      do
      begin
         @(negedge clk);
         cycles++;
         check("fetch_grant_o during flush", fetch_grant_o, 0);
      end while (!ctrl_flush_ack_o);
      check("flush ack latency", cycles, 1);
      @(posedge clk);
      #1;
      ctrl_flush_req_i = 1'b0;
      @(negedge clk);
      check("ctrl_flush_ack_o pulse", ctrl_flush_ack_o, 0);
      for (int s = 0; s < `ICACHE_NUM_SETS; s++)
      begin
         model_valid[0][s] = 1'b0;
         model_valid[1][s] = 1'b0;
      end
   endtask

   // -------------------------------------------------------------------------
   // AXI memory model, samples at the falling edge and drives after the rising
   // -------------------------------------------------------------------------
   initial
   begin : axi_memory
      logic        ar_fire;
      logic        r_fire;
      logic        pending;
      logic [31:0] r_addr;
      int          beat;
      int          ar_wait;
      int          r_gap;
      pending = 1'b0;
      r_addr  = '0;
      beat    = 0;
      ar_wait = 0;
      r_gap   = 0;
      wait (rst_n);
      forever
      begin
         @(negedge clk);
         check("r_ready_o", r_ready_o, pending);     // Ready only while a burst is open
         ar_fire = ar_valid_o && ar_ready_i;
         r_fire  = r_valid_i && r_ready_o;
         if (ar_valid_o && !ar_ready_i)
            ar_wait++;
         else
            ar_wait = 0;
         if (pending && !r_valid_i)
            r_gap++;
         else
            r_gap = 0;
         if (ar_fire)
         begin
            if (pending)
               report_fail("AR was issued while a refill burst was still open");
            check("ar_o.id", ar_o.id, `ICACHE_AXI_ID);
            check("ar_o.addr", ar_o.addr, cur_line);
            check("ar_o.len", ar_o.len, 1);
            check("ar_o.size", ar_o.size, 3);
            check("ar_o.burst", ar_o.burst, 1);
            r_addr = ar_o.addr;
            ar_count++;
         end
         @(posedge clk);
         #1;
         if (ar_fire)
         begin
            pending = 1'b1;
            beat    = 0;
         end
         if (r_fire)
         begin
            beat++;
            if (beat == `ICACHE_BURST_BEATS)
               pending = 1'b0;
         end
         mem_rng    = xorshift32(mem_rng);
         ar_ready_i = !delays || ar_wait >= 3 || mem_rng[0];
         // A raised beat stays until it is taken
         if (r_fire || !r_valid_i)
         begin
            if (pending && (!delays || r_gap >= 3 || mem_rng[7]))
            begin
               r_valid_i = 1'b1;
               r_i.id    = `ICACHE_AXI_ID;
               r_i.data  = mem_word(r_addr + 32'(beat * 8));
               r_i.resp  = 2'b00;
               r_i.last  = (beat == `ICACHE_BURST_BEATS - 1);
            end
            else
               r_valid_i = 1'b0;
         end
      end
   end

   // Response compare
   always @(negedge clk)
   begin
      if (rst_n && fetch_valid_o)
      begin
         if (exp_q.size() == 0)
            report_fail("fetch response arrived with no request outstanding");
         else
            check("fetch_rsp_o", fetch_rsp_o, exp_q.pop_front());
      end
   end

   initial
   begin : watchdog
      #(TIMEOUT_NS);
      report_fail("watchdog expired before all tests completed");
   end

   // -------------------------------------------------------------------------
   // Test sequence
   // -------------------------------------------------------------------------
   initial
   begin : stimulus
      logic [31:0] addr;
      logic        hit;
      clk              = 1'b0;
      rst_n            = 1'b0;
      fetch_req_i      = 1'b0;
      fetch_i          = '0;
      ar_ready_i       = 1'b0;
      r_valid_i        = 1'b0;
      r_i              = '0;
      ctrl_flush_req_i = 1'b0;
      delays           = 1'b0;
      cur_line         = '0;
      stim_rng         = SEED;
      mem_rng          = xorshift32(SEED ^ 32'h2545_f491);
      ar_count         = 0;
      miss_count       = 0;
      for (int s = 0; s < `ICACHE_NUM_SETS; s++)
      begin
         model_valid[0][s] = 1'b0;
         model_valid[1][s] = 1'b0;
         model_victim[s]   = 1'b0;
      end
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // Reset state, then a cold miss
      @(negedge clk);
      check("ctrl_flush_ack_o after reset", ctrl_flush_ack_o, 0);
      check("fetch_valid_o after reset", fetch_valid_o, 0);
      check("ar_valid_o after reset", ar_valid_o, 0);
      check("fetch_grant_o after reset", fetch_grant_o, 1);
      fetch(32'h1000_0048, 8'h3c, hit);
      check("first fetch hit", hit, 0);

      // Same line again
      fetch(32'h1000_0040, 8'h51, hit);
      check("repeat fetch hit", hit, 1);

      // Three tags in set 5
      fetch(32'h0000_0150, 8'h01, hit);
      fetch(32'h0000_0250, 8'h02, hit);
      fetch(32'h0000_0158, 8'h03, hit);
      check("first tag hit", hit, 1);
      fetch(32'h0000_025c, 8'h04, hit);
      check("second tag hit", hit, 1);
      fetch(32'h0000_0350, 8'h05, hit);
      check("third tag hit", hit, 0);
      fetch(32'h0000_0254, 8'h06, hit);
      check("surviving tag hit", hit, 1);
      fetch(32'h0000_0150, 8'h07, hit);
      check("evicted tag hit", hit, 0);

      // Flush, then everything cached misses
      flush_cache();
      fetch(32'h1000_0040, 8'h11, hit);
      check("line after flush hit", hit, 0);
      fetch(32'h0000_0350, 8'h12, hit);
      check("line after flush hit", hit, 0);
      fetch(32'h0000_0150, 8'h13, hit);
      check("line after flush hit", hit, 0);

      // Random stream with AXI stalls
      delays = 1'b1;
      for (int i = 0; i < 200; i++)
      begin
         stim_rng = xorshift32(stim_rng);
         addr     = 32'h0004_0000 + {22'd0, stim_rng[9:0]};
         fetch(addr, stim_rng[23:16], hit);
      end
      check("AR count against model misses", ar_count, miss_count);
      check("responses outstanding", exp_q.size(), 0);

      $display("Finished with no errors");
      $finish;
   end

endmodule

//--- shared_icache.f
+incdir+hdl
hdl/icache_pkg.sv
hdl/icache_tag_array.sv
hdl/icache_data_array.sv
hdl/icache_refill.sv
hdl/icache_ctrl.sv
hdl/shared_icache.sv
dv/tb_shared_icache.sv

//--- Makefile
# Verilator build and run of the shared instruction cache testbench

VERILATOR ?= verilator
TOP       ?= tb_shared_icache
FILELIST  ?= shared_icache.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
FAIL_MSG  ?= Finished with errors
PASS_MSG  ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "TEST FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "TEST INCOMPLETE"; exit 1; fi
	@echo "TEST PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
